//--- dbgmon.f
verilog/dbgmon_pkg.sv
verilog/trace_ram.sv
verilog/dbgmon_regs.sv
verilog/dbgmon_trigger.sv
verilog/dbgmon_trace.sv
verilog/dbgmon.sv
verif/dbgmon_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f dbgmon.f --top-module dbgmon_tb -o dbgmon_sim

out=$(./obj_dir/dbgmon_sim 2>&1) || true
echo "$out"

echo "$out" | grep -q "^TB PASSED$"
echo "simulation passed"

//--- verif/dbgmon_tb.sv
`timescale 1ns/1ns

module dbgmon_tb;

localparam int TIMEOUT_CYCLES = 20000; // the full sequence needs under 9000.

logic                    clk;
logic                    rstn;
dbgmon_pkg::apb_req_t    apb_req;
dbgmon_pkg::apb_rsp_t    apb_rsp;
dbgmon_pkg::addr_t       pc;
logic                    commit_valid;
dbgmon_pkg::commit_pkg_t commit;
logic                    halt_req;

// model registers by word index (0x010 is index 4 and freeze is 15).
dbgmon_pkg::word_t       m_reg [16];
logic                    m_counting;
dbgmon_pkg::delay_t      m_cnt;
dbgmon_pkg::trace_idx_t  m_wptr;
dbgmon_pkg::commit_pkg_t ring [dbgmon_pkg::TRACE_DEPTH];
logic [31:0]             seed;
int                      halts;
int                      cycles = 0;

dbgmon dut (
    .clk          ( clk          ),
    .rstn         ( rstn         ),
    .apb_req      ( apb_req      ),
    .apb_rsp      ( apb_rsp      ),
    .pc           ( pc           ),
    .commit_valid ( commit_valid ),
    .commit       ( commit       ),
    .halt_req     ( halt_req     )
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end
end

function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
endfunction

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        $display("TB FAILED");
        $fatal(1, "check failed");
    end
endtask

// apb slave never stalls and never errors.
task automatic check_rsp_status();
    check_value("pready", {31'b0, apb_rsp.pready}, 32'd1);
    check_value("pslverr", {31'b0, apb_rsp.pslverr}, 32'd0);
endtask

// small pc and address pools so that triggers actually hit.
function automatic dbgmon_pkg::commit_pkg_t rand_pkg(input logic no_trap);
    dbgmon_pkg::commit_pkg_t p;
    logic [31:0]             r;
    r = next_rand();
    p.kind = r[31:30];
    if (no_trap && p.kind == dbgmon_pkg::KIND_TRAP)
        p.kind = dbgmon_pkg::KIND_ALU;
    p.pc   = 32'h0000_1000 + {25'b0, r[29:24], 1'b0};
    p.addr = {r[23], 26'b0, r[22:18]}; // traps read this as irq flag and cause.
    p.data = next_rand();
    return p;
endfunction

function automatic logic model_match(input dbgmon_pkg::commit_pkg_t p);
    logic       hit;
    logic       is_trap;
    logic       is_mem;
    logic [4:0] cause;
    hit     = 1'b0;
    cause   = p.addr[4:0];
    is_trap = p.kind == dbgmon_pkg::KIND_TRAP;
    is_mem  = p.kind == dbgmon_pkg::KIND_LOAD || p.kind == dbgmon_pkg::KIND_STORE;
    for (int i = 0; i < 4; i++) begin
        if (m_reg[4+i][31] && !is_trap && m_reg[4+i][30:0] == p.pc[31:1])
            hit = 1'b1;
        if (m_reg[8+i][31] && is_mem && m_reg[8+i][30:0] == p.addr[31:1])
            hit = 1'b1;
    end
    if (is_trap && cause != 5'd31) begin // masks cover causes 0..30.
        if (!p.addr[31] && m_reg[12][31] && m_reg[12][cause])
            hit = 1'b1;
        if (p.addr[31] && m_reg[13][31] && m_reg[13][cause])
            hit = 1'b1;
    end
    return hit;
endfunction

function automatic dbgmon_pkg::word_t expected_reg(input dbgmon_pkg::paddr_t a);
    if (a[11:6] != 6'd0 || a[5:4] == 2'd0)
        return '0;
    if (a == dbgmon_pkg::REG_DELAY)
        return m_reg[14] & 32'h0000_ffff;
    if (a == dbgmon_pkg::REG_FREEZE)
        return m_reg[15] & 32'h0000_0001;
    return m_reg[a[5:2]];
endfunction

// one cycle of the commit port with halt_req checked before the edge.
task automatic commit_cycle(input logic v, input dbgmon_pkg::commit_pkg_t p);
    logic exp_halt;
    @(posedge clk);
    #1;
    apb_req      = '0;
    commit_valid = v;
    commit       = p;
    pc           = p.pc;
    exp_halt     = 1'b0;
    if (v && !m_counting && model_match(p)) begin
        if (m_reg[14][15:0] == 16'd0) begin
            exp_halt = 1'b1;
        end
        else begin
            m_counting = 1'b1;
            m_cnt      = m_reg[14][15:0];
        end
    end
    else if (v && m_counting) begin
        exp_halt   = m_cnt == 16'd1;
        m_counting = m_cnt != 16'd1;
        m_cnt      = m_cnt - 16'd1;
    end
    @(negedge clk);
    check_value("halt_req", {31'b0, halt_req}, {31'b0, exp_halt});
    if (v && !m_reg[15][0]) begin
        ring[m_wptr] = p;
        m_wptr       = m_wptr + 5'd1;
    end
    if (exp_halt) begin
        m_reg[15][0] = 1'b1;
        halts++;
    end
endtask

// stops tail packages after the first halt.
task automatic drive_commits(input int max_pkts, input int tail, input logic no_trap);
    int          sent;
    int          after;
    logic [31:0] r;
    halts = 0;
    sent  = 0;
    after = 0;
    while (sent < max_pkts && (halts == 0 || after < tail)) begin
        r = next_rand();
        if (r[31:29] == 3'd0) begin
            commit_cycle(1'b0, rand_pkg(no_trap));
        end
        else begin
            if (halts != 0)
                after++;
            commit_cycle(1'b1, rand_pkg(no_trap));
            sent++;
        end
    end
endtask

task automatic apb_write(input dbgmon_pkg::paddr_t a, input dbgmon_pkg::word_t d);
    @(posedge clk);
    #1;
    commit_valid    = 1'b0;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = a;
    apb_req.pwdata  = d;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    if (a[11:6] == 6'd0 && a[5:4] != 2'd0)
        m_reg[a[5:2]] = d;
    @(negedge clk);
    check_rsp_status();
    @(posedge clk);
    #1;
    apb_req = '0;
endtask

task automatic apb_read(input dbgmon_pkg::paddr_t a, input dbgmon_pkg::word_t exp,
                        input string what);
    @(posedge clk);
    #1;
    commit_valid    = 1'b0;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = a;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    check_value(what, apb_rsp.prdata, exp);
    check_rsp_status();
    @(posedge clk);
    #1;
    apb_req = '0;
endtask

task automatic clear_config();
    for (int k = 4; k < 16; k++)
        apb_write(12'(k * 4), '0);
endtask

// index 0 is the oldest entry.
task automatic check_trace();
    dbgmon_pkg::commit_pkg_t e;
    dbgmon_pkg::paddr_t      a;
    for (int i = 0; i < dbgmon_pkg::TRACE_DEPTH; i++) begin
        e = ring[m_wptr + 5'(i)];
        a = dbgmon_pkg::TRACE_BASE + 12'(i * 16);
        apb_read(a, e.pc, "trace pc");
        apb_read(a + 12'd4, e.addr, "trace addr");
        apb_read(a + 12'd8, e.data, "trace data");
        apb_read(a + 12'd12, {30'b0, e.kind}, "trace kind");
    end
endtask

initial begin
    dbgmon_pkg::commit_pkg_t p;
    dbgmon_pkg::paddr_t      a;
    logic [31:0]             r;
    seed         = 32'h65ec;
    rstn         = 1'b0;
    apb_req      = '0;
    pc           = '0;
    commit_valid = 1'b0;
    commit       = '0;
    m_counting   = 1'b0;
    m_cnt        = '0;
    m_wptr       = '0;
    halts        = 0;
    for (int k = 0; k < 16; k++)
        m_reg[k] = '0;
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;

    // register readback.
    for (int k = 4; k < 16; k++)
        apb_write(12'(k * 4), next_rand());
    for (int k = 4; k < 16; k++)
        apb_read(12'(k * 4), expected_reg(12'(k * 4)), "config readback");
    pc = next_rand();
    apb_read(dbgmon_pkg::REG_PC, pc, "live pc");
    for (int k = 0; k < 8; k++) begin
        r = next_rand();
        a = (k == 0) ? 12'h004 : (12'h040 | {1'b0, r[31:23], 2'b0});
        apb_read(a, 32'h0, "unmapped address");
    end

    // single breakpoint with zero delay.
    clear_config();
    p = rand_pkg(1'b1);
    r = next_rand();
    apb_write(dbgmon_pkg::REG_BP0 + {8'b0, r[31:30], 2'b0}, {1'b1, p.pc[31:1]});
    drive_commits(400, 4, 1'b1);
    check_value("breakpoint halt seen", {31'b0, halts != 0}, 32'd1);

    // watchpoints and trap masks.
    for (int round = 0; round < 6; round++) begin
        for (int i = 0; i < 4; i++) begin
            p = rand_pkg(1'b0);
            r = next_rand();
            apb_write(dbgmon_pkg::REG_BP0 + 12'(i * 4), {r[31], p.pc[31:1]});
            apb_write(dbgmon_pkg::REG_WP0 + 12'(i * 4), {r[30], p.addr[31:1]});
        end
        apb_write(dbgmon_pkg::REG_EXC, next_rand());
        apb_write(dbgmon_pkg::REG_IRQ, next_rand());
        drive_commits(300, 8, 1'b0);
    end

    // delay of 1 to 8 packages.
    for (int round = 0; round < 5; round++) begin
        clear_config();
        p = rand_pkg(1'b1);
        r = next_rand();
        apb_write(dbgmon_pkg::REG_DELAY, {29'b0, r[31:29]} + 32'd1);
        apb_write(dbgmon_pkg::REG_BP0 + {8'b0, r[28:27], 2'b0}, {1'b1, p.pc[31:1]});
        drive_commits(400, 12, 1'b0);
        check_value("delayed halt seen", {31'b0, halts != 0}, 32'd1);
    end

    // trace readback after flushing any pending delay count.
    clear_config();
    drive_commits(16, 100, 1'b0);
    apb_write(dbgmon_pkg::REG_FREEZE, 32'd0);
    drive_commits(40, 0, 1'b0);
    p = rand_pkg(1'b0);
    apb_write(dbgmon_pkg::REG_BP2, {1'b1, p.pc[31:1]});
    drive_commits(400, 0, 1'b0);
    check_value("trace halt seen", {31'b0, halts != 0}, 32'd1);
    apb_read(dbgmon_pkg::REG_FREEZE, 32'd1, "frozen flag");
    check_trace();
    drive_commits(24, 100, 1'b0); // buffer must hold while frozen.
    check_trace();
    clear_config();
    drive_commits(20, 100, 1'b0);
    apb_write(dbgmon_pkg::REG_FREEZE, 32'd1);
    check_trace();

    $display("TB PASSED");
    $finish;
end

endmodule

//--- verilog/dbgmon.sv
`timescale 1ns/1ns

module dbgmon (
    input                              clk,
    input                              rstn,

    input  dbgmon_pkg::apb_req_t       apb_req,
    output dbgmon_pkg::apb_rsp_t       apb_rsp,

    input  dbgmon_pkg::addr_t          pc,

    input                              commit_valid,
    input  dbgmon_pkg::commit_pkg_t    commit,

    output logic                       halt_req
);

dbgmon_pkg::trig_cfg_t  cfg;
logic                   freeze_we;
logic                   freeze_val;
logic                   frozen;
dbgmon_pkg::trace_idx_t trace_rd_idx;
logic [1:0]             trace_rd_word;
dbgmon_pkg::word_t      trace_rdata;

dbgmon_regs u_regs (
    .clk           ( clk           ),
    .rstn          ( rstn          ),
    .apb_req       ( apb_req       ),
    .apb_rsp       ( apb_rsp       ),
    .pc            ( pc            ),
    .frozen        ( frozen        ),
    .trace_rdata   ( trace_rdata   ),
    .cfg           ( cfg           ),
    .freeze_we     ( freeze_we     ),
    .freeze_val    ( freeze_val    ),
    .trace_rd_idx  ( trace_rd_idx  ),
    .trace_rd_word ( trace_rd_word )
);

dbgmon_trigger u_trigger (
    .clk          ( clk          ),
    .rstn         ( rstn         ),
    .cfg          ( cfg          ),
    .commit_valid ( commit_valid ),
    .commit       ( commit       ),
    .halt_req     ( halt_req     )
);

dbgmon_trace u_trace (
    .clk           ( clk           ),
    .rstn          ( rstn          ),
    .commit_valid  ( commit_valid  ),
    .commit        ( commit        ),
    .halt_req      ( halt_req      ),
    .freeze_we     ( freeze_we     ),
    .freeze_val    ( freeze_val    ),
    .trace_rd_idx  ( trace_rd_idx  ),
    .trace_rd_word ( trace_rd_word ),
    .frozen        ( frozen        ),
    .trace_rdata   ( trace_rdata   )
);

endmodule

//--- verilog/dbgmon_pkg.sv
package dbgmon_pkg;

typedef logic [31:0] word_t;
typedef logic [31:0] addr_t;
typedef logic [11:0] paddr_t;
typedef logic [15:0] delay_t;
typedef logic [ 4:0] trace_idx_t;
typedef logic [ 1:0] kind_t;

localparam int TRACE_DEPTH = 32;

localparam kind_t KIND_ALU   = 2'd0;
localparam kind_t KIND_LOAD  = 2'd1;
localparam kind_t KIND_STORE = 2'd2;
localparam kind_t KIND_TRAP  = 2'd3;

// register map, byte addresses.
localparam paddr_t REG_PC     = 12'h000;
localparam paddr_t REG_BP0    = 12'h010;
localparam paddr_t REG_BP1    = 12'h014;
localparam paddr_t REG_BP2    = 12'h018;
localparam paddr_t REG_BP3    = 12'h01C;
localparam paddr_t REG_WP0    = 12'h020;
localparam paddr_t REG_WP1    = 12'h024;
localparam paddr_t REG_WP2    = 12'h028;
localparam paddr_t REG_WP3    = 12'h02C;
localparam paddr_t REG_EXC    = 12'h030;
localparam paddr_t REG_IRQ    = 12'h034;
localparam paddr_t REG_DELAY  = 12'h038;
localparam paddr_t REG_FREEZE = 12'h03C;
localparam paddr_t TRACE_BASE = 12'h800; // bit 11 opens the trace window.

// one retired instruction; for traps addr holds the cause and irq flag.
typedef struct packed {
    kind_t kind;
    addr_t pc;
    addr_t addr;
    word_t data;
} commit_pkg_t;

typedef struct packed {
    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    word_t  pwdata;
} apb_req_t;

typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
} apb_rsp_t;

// enable sits in bit 31 of every word.
typedef struct packed {
    word_t [3:0] bp;
    word_t [3:0] wp;
    word_t       exc;
    word_t       irq;
    delay_t      delay;
} trig_cfg_t;

typedef enum logic [0:0] {
    TRIG_IDLE,
    TRIG_COUNT
} trig_state_t;

endpackage

//--- verilog/dbgmon_regs.sv
`timescale 1ns/1ns

module dbgmon_regs (
    input                              clk,
    input                              rstn,

    input  dbgmon_pkg::apb_req_t       apb_req,
    output dbgmon_pkg::apb_rsp_t       apb_rsp,

    input  dbgmon_pkg::addr_t          pc,
    input                              frozen,
    input  dbgmon_pkg::word_t          trace_rdata,

    output dbgmon_pkg::trig_cfg_t      cfg,
    output logic                       freeze_we,
    output logic                       freeze_val,
    output dbgmon_pkg::trace_idx_t     trace_rd_idx,
    output logic [1:0]                 trace_rd_word
);

logic              setup;
logic              wr_en;
logic              rd_en;
logic              trace_win;
logic [3:0]        bp_hit;
logic [3:0]        wp_hit;
dbgmon_pkg::word_t rd_word;
dbgmon_pkg::word_t rd_word_q;
logic              trace_sel_q;

// both writes and reads act on the setup cycle.
assign setup     = apb_req.psel && ~apb_req.penable;
assign wr_en     = setup &&  apb_req.pwrite;
assign rd_en     = setup && ~apb_req.pwrite;
assign trace_win = apb_req.paddr >= dbgmon_pkg::TRACE_BASE;

assign bp_hit = {apb_req.paddr == dbgmon_pkg::REG_BP3,
                 apb_req.paddr == dbgmon_pkg::REG_BP2,
                 apb_req.paddr == dbgmon_pkg::REG_BP1,
                 apb_req.paddr == dbgmon_pkg::REG_BP0};

assign wp_hit = {apb_req.paddr == dbgmon_pkg::REG_WP3,
                 apb_req.paddr == dbgmon_pkg::REG_WP2,
                 apb_req.paddr == dbgmon_pkg::REG_WP1,
                 apb_req.paddr == dbgmon_pkg::REG_WP0};

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        cfg <= '0;
    end
    else if (wr_en) begin
        for (int i = 0; i < 4; i++) begin
            if (bp_hit[i])
                cfg.bp[i] <= apb_req.pwdata;
            if (wp_hit[i])
                cfg.wp[i] <= apb_req.pwdata;
        end
        if (apb_req.paddr == dbgmon_pkg::REG_EXC)
            cfg.exc <= apb_req.pwdata;
        if (apb_req.paddr == dbgmon_pkg::REG_IRQ)
            cfg.irq <= apb_req.pwdata;
        if (apb_req.paddr == dbgmon_pkg::REG_DELAY)
            cfg.delay <= apb_req.pwdata[15:0];
    end
end

// the freeze flag itself lives with the trace pointer.
assign freeze_we  = wr_en && (apb_req.paddr == dbgmon_pkg::REG_FREEZE);
assign freeze_val = apb_req.pwdata[0];

assign trace_rd_idx  = apb_req.paddr[8:4]; // relative to oldest entry.
assign trace_rd_word = apb_req.paddr[3:2];

always_comb begin
    rd_word = '0; // unmapped reads as zero.
    case (apb_req.paddr)
        dbgmon_pkg::REG_PC:     rd_word = pc;
        dbgmon_pkg::REG_BP0:    rd_word = cfg.bp[0];
        dbgmon_pkg::REG_BP1:    rd_word = cfg.bp[1];
        dbgmon_pkg::REG_BP2:    rd_word = cfg.bp[2];
        dbgmon_pkg::REG_BP3:    rd_word = cfg.bp[3];
        dbgmon_pkg::REG_WP0:    rd_word = cfg.wp[0];
        dbgmon_pkg::REG_WP1:    rd_word = cfg.wp[1];
        dbgmon_pkg::REG_WP2:    rd_word = cfg.wp[2];
        dbgmon_pkg::REG_WP3:    rd_word = cfg.wp[3];
        dbgmon_pkg::REG_EXC:    rd_word = cfg.exc;
        dbgmon_pkg::REG_IRQ:    rd_word = cfg.irq;
        dbgmon_pkg::REG_DELAY:  rd_word = {16'b0, cfg.delay};
        dbgmon_pkg::REG_FREEZE: rd_word = {31'b0, frozen};
        default:                rd_word = '0;
    endcase
end

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        rd_word_q   <= '0;
        trace_sel_q <= 1'b0;
    end
    else if (rd_en) begin
        rd_word_q   <= rd_word;
        trace_sel_q <= trace_win;
    end
end

// ram output and register word are both valid in the access cycle.
always_comb begin
    apb_rsp.prdata  = trace_sel_q ? trace_rdata : rd_word_q;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = 1'b0;
end

endmodule

//--- verilog/dbgmon_trace.sv
`timescale 1ns/1ns

module dbgmon_trace (
    input                              clk,
    input                              rstn,

    input                              commit_valid,
    input  dbgmon_pkg::commit_pkg_t    commit,
    input                              halt_req,

    input                              freeze_we,
    input                              freeze_val,
    input  dbgmon_pkg::trace_idx_t     trace_rd_idx,
    input  logic [1:0]                 trace_rd_word,

    output logic                       frozen,
    output dbgmon_pkg::word_t          trace_rdata
);

dbgmon_pkg::trace_idx_t wptr;
dbgmon_pkg::trace_idx_t ram_addr;
logic                   ram_we;
logic [127:0]           ram_wdata;
logic [127:0]           ram_rdata;
logic [1:0]             word_q;

assign ram_we    = commit_valid && ~frozen;
assign ram_wdata = {dbgmon_pkg::word_t'(commit.kind), commit.data, commit.addr, commit.pc};

// once frozen, wptr points at the oldest entry.
assign ram_addr = frozen ? wptr + trace_rd_idx : wptr;

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn)
        wptr <= '0;
    else if (ram_we)
        wptr <= wptr + 5'd1;
end

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn)
        frozen <= 1'b0;
    else if (halt_req)
        frozen <= 1'b1; // halt beats a host write.
    else if (freeze_we)
        frozen <= freeze_val;
end

always_ff @(posedge clk) begin
    word_q <= trace_rd_word;
end

trace_ram u_trace_ram (
    .clk   ( clk       ),
    .we    ( ram_we    ),
    .addr  ( ram_addr  ),
    .wdata ( ram_wdata ),
    .rdata ( ram_rdata )
);

assign trace_rdata = ram_rdata[32*word_q +: 32];

endmodule

//--- verilog/dbgmon_trigger.sv
`timescale 1ns/1ns

module dbgmon_trigger (
    input                              clk,
    input                              rstn,

    input  dbgmon_pkg::trig_cfg_t      cfg,

    input                              commit_valid,
    input  dbgmon_pkg::commit_pkg_t    commit,

    output logic                       halt_req
);

logic                    is_insn;
logic                    is_mem;
logic                    is_trap;
logic [3:0]              bp_match;
logic [3:0]              wp_match;
logic [4:0]              cause;
logic                    cause_ok;
logic                    exc_match;
logic                    irq_match;
logic                    match;
dbgmon_pkg::trig_state_t state;
dbgmon_pkg::delay_t      cnt;

always_comb begin
    is_insn = 1'b0;
    is_mem  = 1'b0;
    is_trap = 1'b0;
    case (commit.kind)
        dbgmon_pkg::KIND_ALU: begin
            is_insn = 1'b1;
        end
        dbgmon_pkg::KIND_LOAD,
        dbgmon_pkg::KIND_STORE: begin
            is_insn = 1'b1;
            is_mem  = 1'b1;
        end
        dbgmon_pkg::KIND_TRAP: begin
            is_trap = 1'b1;
        end
        default: begin
            is_insn = 1'b0;
        end
    endcase
end

// halfword aligned, so bit 0 of pc and addr is not compared.
always_comb begin
    for (int i = 0; i < 4; i++) begin
        bp_match[i] = cfg.bp[i][31] && is_insn && (cfg.bp[i][30:0] == commit.pc[31:1]);
        wp_match[i] = cfg.wp[i][31] && is_mem && (cfg.wp[i][30:0] == commit.addr[31:1]);
    end
end

assign cause    = commit.addr[4:0];
assign cause_ok = cause != 5'd31; // bit 31 is the enable, not a cause.

assign exc_match = cfg.exc[31] && is_trap && ~commit.addr[31] && cause_ok && cfg.exc[cause];
assign irq_match = cfg.irq[31] && is_trap &&  commit.addr[31] && cause_ok && cfg.irq[cause];

assign match = commit_valid && (|bp_match || |wp_match || exc_match || irq_match);

// zero delay halts on the match itself.
assign halt_req = commit_valid &&
                  (((state == dbgmon_pkg::TRIG_IDLE) && match && (cfg.delay == '0)) ||
                   ((state == dbgmon_pkg::TRIG_COUNT) && (cnt == 16'd1)));

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        state <= dbgmon_pkg::TRIG_IDLE;
        cnt   <= '0;
    end
    else begin
        case (state)
            dbgmon_pkg::TRIG_IDLE: begin
                if (match && (cfg.delay != '0)) begin
                    state <= dbgmon_pkg::TRIG_COUNT;
                    cnt   <= cfg.delay;
                end
            end
            dbgmon_pkg::TRIG_COUNT: begin
                if (commit_valid) begin // matches while counting are ignored.
                    cnt <= cnt - 16'd1;
                    if (cnt == 16'd1)
                        state <= dbgmon_pkg::TRIG_IDLE;
                end
            end
            default: begin
                state <= dbgmon_pkg::TRIG_IDLE;
            end
        endcase
    end
end

endmodule

//--- verilog/trace_ram.sv
`timescale 1ns/1ns

module trace_ram (
    input                              clk,
    input                              we,
    input  dbgmon_pkg::trace_idx_t     addr,
    input  logic [127:0]               wdata,
    output logic [127:0]               rdata
);

logic [127:0] mem [dbgmon_pkg::TRACE_DEPTH];

// read returns the old line on a write cycle.
always_ff @(posedge clk) begin
    if (we)
        mem[addr] <= wdata;
    rdata <= mem[addr];
end

endmodule
